/* Bender.yml */
package:
  name: bfly_engine

sources:
  - bfly_pkg.sv
  - sample_packer.sv
  - lane_crossbar.sv
  - bfly_unit.sv
  - bfly_datapath.sv
  - engine_cfg_regs.sv
  - bfly_engine_top.sv
  - target: test
    files:
      - tb_bfly_engine.sv

/* bfly_datapath.sv */
// Butterfly datapath with permute and recover

`timescale 1ns/100ps

module bfly_datapath import bfly_pkg::*; #(
  parameter int data_width = DATA_WIDTH,
  parameter int bu_par     = BU_PAR,
  parameter int frac_bits  = FRAC_BITS
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 vec_vld,
  input  logic [2*bu_par*data_width-1:0]       vec_dat,
  input  logic [2*bu_par*$clog2(2*bu_par)-1:0] permute_sel,
  input  logic [2*bu_par*$clog2(2*bu_par)-1:0] recover_sel,
  input  logic [4*bu_par*data_width-1:0]       coefs,
  output logic                                 dn_vld,
  output logic [2*bu_par*data_width-1:0]       dn_dat
);

  localparam int lanes    = 2 * bu_par;
  localparam int sel_bits = lanes * $clog2(lanes);
  localparam int vec_w    = lanes * data_width;

  logic [vec_w-1:0]             permuted;
  logic [vec_w-1:0]             cap_lanes;   // Captured permuted group
  logic [4*bu_par*data_width-1:0] cap_coefs;
  logic                         cap_vld;
  logic [sel_bits-1:0]          rec_pipe [BFLY_LATENCY+1];
  logic [bu_par-1:0]            unit_vld;
  logic [vec_w-1:0]             bfly_out;
  logic [vec_w-1:0]             recovered;

  lane_crossbar #(.data_width(data_width), .bu_par(bu_par)) permute_xbar_i (
    .lanes_in  (vec_dat),
    .sel       (permute_sel),
    .lanes_out (permuted)
  );

  ////////////////////////////////////////////////////////////
  // Input capture and recover select delay line
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) cap_vld <= 1'b0;
    else        cap_vld <= vec_vld;
  end

  always_ff @(posedge clk) begin
    if (vec_vld) begin
      cap_lanes   <= permuted;
      cap_coefs   <= coefs;
      rec_pipe[0] <= recover_sel;  // Captured select travels with the group
    end
    // Keeps step with the butterfly stages
    for (int s = 1; s <= BFLY_LATENCY; s++) begin
      rec_pipe[s] <= rec_pipe[s-1];
    end
  end

  // Unit u works on lanes 2u and 2u+1 with coefficients 4u to 4u+3
  for (genvar u = 0; u < bu_par; u++) begin : g_unit
    bfly_unit #(.data_width(data_width), .frac_bits(frac_bits)) unit_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_vld  (cap_vld),
      .x1      (cap_lanes[(2*u)*data_width +: data_width]),
      .x2      (cap_lanes[(2*u+1)*data_width +: data_width]),
      .w1      (cap_coefs[(4*u)*data_width +: data_width]),
      .w2      (cap_coefs[(4*u+1)*data_width +: data_width]),
      .w3      (cap_coefs[(4*u+2)*data_width +: data_width]),
      .w4      (cap_coefs[(4*u+3)*data_width +: data_width]),
      .out_vld (unit_vld[u]),
      .y1      (bfly_out[(2*u)*data_width +: data_width]),
      .y2      (bfly_out[(2*u+1)*data_width +: data_width])
    );
  end

  lane_crossbar #(.data_width(data_width), .bu_par(bu_par)) recover_xbar_i (
    .lanes_in  (bfly_out),
    .sel       (rec_pipe[BFLY_LATENCY]),
    .lanes_out (recovered)
  );

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) dn_vld <= 1'b0;
    else        dn_vld <= unit_vld[0];  // All units run in lockstep
  end

  always_ff @(posedge clk) begin
    if (unit_vld[0]) dn_dat <= recovered;
  end

endmodule

/* bfly_engine_top.sv */
// Streaming butterfly engine top

`timescale 1ns/100ps

module bfly_engine_top import bfly_pkg::*; #(
  parameter int data_width = DATA_WIDTH,
  parameter int bu_par     = BU_PAR,
  parameter int frac_bits  = FRAC_BITS
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           up_vld,
  input  logic signed [data_width-1:0]   up_dat,
  input  logic                           cfg_we,
  input  logic [CFG_ADDR_W-1:0]          cfg_addr,
  input  logic [CFG_DATA_W-1:0]          cfg_wdata,
  output logic                           dn_vld,
  output logic [2*bu_par*data_width-1:0] dn_dat
);

  logic                                 vec_vld;
  logic [2*bu_par*data_width-1:0]       vec_dat;
  logic [2*bu_par*$clog2(2*bu_par)-1:0] permute_sel;
  logic [2*bu_par*$clog2(2*bu_par)-1:0] recover_sel;
  logic [4*bu_par*data_width-1:0]       coefs;

  sample_packer #(.data_width(data_width), .bu_par(bu_par)) packer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .up_vld  (up_vld),
    .up_dat  (up_dat),
    .vec_vld (vec_vld),
    .vec_dat (vec_dat)
  );

  engine_cfg_regs #(.data_width(data_width), .bu_par(bu_par)) cfg_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .permute_sel (permute_sel),
    .recover_sel (recover_sel),
    .coefs       (coefs)
  );

  bfly_datapath #(
    .data_width (data_width),
    .bu_par     (bu_par),
    .frac_bits  (frac_bits)
  ) datapath_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .vec_vld     (vec_vld),
    .vec_dat     (vec_dat),
    .permute_sel (permute_sel),
    .recover_sel (recover_sel),
    .coefs       (coefs),
    .dn_vld      (dn_vld),
    .dn_dat      (dn_dat)
  );

endmodule

/* bfly_input.txt */
# W addr data writes one config word
# S gap s0 to s7 sends a group with gap idle cycles after s3
# E e0 to e7 holds the expected lanes in hex
S 0 1234 0001 ffff 8000 7fff 0100 0abc 4000
E 0000 0000 0000 0000 0000 0000 0000 0000
W 2 00004000
W 3 40000000
W 4 00004000
W 5 40000000
W 6 00004000
W 7 40000000
W 8 00004000
W 9 40000000
S 0 1234 0001 ffff 8000 7fff 0100 0abc 4000
E 1234 0001 ffff 8000 7fff 0100 0abc 4000
S 0 0011 0022 0033 0044 0055 0066 0077 0088
E 0011 0022 0033 0044 0055 0066 0077 0088
S 0 f00f e00e d00d c00c b00b a00a 9009 8008
E f00f e00e d00d c00c b00b a00a 9009 8008
W 0 00053977
W 1 001f58d1
S 0 0a00 0a01 0a02 0a03 0a04 0a05 0a06 0a07
E 0a06 0a05 0a04 0a03 0a02 0a01 0a00 0a07
W 1 00fac688
S 6 0a00 0a01 0a02 0a03 0a04 0a05 0a06 0a07
E 0a07 0a06 0a05 0a04 0a03 0a02 0a01 0a00
W 0 00fac688
W 2 c0002000
W 3 60004000
W 4 80007fff
W 5 e0007fff
W 8 00013000
W 9 0000ffff
S 0 1000 2000 7000 6000 8001 1357 fffd 0005
E 2800 2000 9ffc f000 8001 1357 fffd ffff

/* bfly_pkg.sv */
// Butterfly engine shared definitions

package bfly_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath defaults
  ////////////////////////////////////////////////////////////

  // Signed sample width
  localparam int DATA_WIDTH = 16;

  // Butterfly units with two vector lanes each
  localparam int BU_PAR = 4;

  // Fraction bits so 1.0 is 0x4000
  localparam int FRAC_BITS = 14;

  // Product stage plus sum stage
  localparam int BFLY_LATENCY = 2;

  ////////////////////////////////////////////////////////////
  // Configuration bus and word map
  ////////////////////////////////////////////////////////////

  localparam int CFG_ADDR_W = 4;   // Word address
  localparam int CFG_DATA_W = 32;  // Word data

  localparam int CFG_PERMUTE_ADDR = 0;  // Lane permute select
  localparam int CFG_RECOVER_ADDR = 1;  // Lane recover select

  // Two coefficients per word from here on
  // Low half holds the even flat index and high half the odd one
  localparam int CFG_COEF_BASE = 2;

endpackage

/* bfly_unit.sv */
// Pipelined real butterfly

`timescale 1ns/100ps

module bfly_unit import bfly_pkg::*; #(
  parameter int data_width = DATA_WIDTH,
  parameter int frac_bits  = FRAC_BITS
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_vld,
  input  logic signed [data_width-1:0] x1,
  input  logic signed [data_width-1:0] x2,
  input  logic signed [data_width-1:0] w1,
  input  logic signed [data_width-1:0] w2,
  input  logic signed [data_width-1:0] w3,
  input  logic signed [data_width-1:0] w4,
  output logic                         out_vld,
  output logic signed [data_width-1:0] y1,
  output logic signed [data_width-1:0] y2
);

  localparam int prod_w = 2 * data_width;

  logic signed [prod_w-1:0] p_x1w1, p_x1w2, p_x2w3, p_x2w4;
  logic signed [prod_w:0]   sum1, sum2;    // One guard bit
  logic signed [prod_w:0]   sum1_sh, sum2_sh;
  logic                     vld_s1;

  // Valid follows the data through both stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_s1  <= 1'b0;
      out_vld <= 1'b0;
    end else begin
      vld_s1  <= in_vld;
      out_vld <= vld_s1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage one registers full width products
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    p_x1w1 <= x1 * w1;
    p_x1w2 <= x1 * w2;
    p_x2w3 <= x2 * w3;
    p_x2w4 <= x2 * w4;
  end

  ////////////////////////////////////////////////////////////
  // Stage two sums then scales back and wraps
  ////////////////////////////////////////////////////////////
  assign sum1    = p_x1w1 + p_x2w3;
  assign sum2    = p_x1w2 + p_x2w4;
  assign sum1_sh = sum1 >>> frac_bits;
  assign sum2_sh = sum2 >>> frac_bits;

  always_ff @(posedge clk) begin
    y1 <= sum1_sh[data_width-1:0];  // Low bits only
    y2 <= sum2_sh[data_width-1:0];
  end

endmodule

/* engine_cfg_regs.sv */
// Engine configuration registers

`timescale 1ns/100ps

module engine_cfg_regs import bfly_pkg::*; #(
  parameter int data_width = DATA_WIDTH,
  parameter int bu_par     = BU_PAR
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 cfg_we,
  input  logic [CFG_ADDR_W-1:0]                cfg_addr,
  input  logic [CFG_DATA_W-1:0]                cfg_wdata,
  output logic [2*bu_par*$clog2(2*bu_par)-1:0] permute_sel,
  output logic [2*bu_par*$clog2(2*bu_par)-1:0] recover_sel,
  output logic [4*bu_par*data_width-1:0]       coefs
);

  localparam int lanes        = 2 * bu_par;
  localparam int sel_w        = $clog2(lanes);
  localparam int sel_bits     = lanes * sel_w;
  localparam int n_coef       = 4 * bu_par;
  localparam int n_coef_words = n_coef / 2;

  logic [data_width-1:0] coef_q [n_coef];

  // Field i selects lane i
  function automatic logic [sel_bits-1:0] identity_sel();
    logic [sel_bits-1:0] s;
    s = '0;
    for (int i = 0; i < lanes; i++) begin
      s[i*sel_w +: sel_w] = sel_w'(i);
    end
    return s;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      permute_sel <= identity_sel();
      recover_sel <= identity_sel();
      for (int n = 0; n < n_coef; n++) coef_q[n] <= '0;
    end else if (cfg_we) begin
      if (cfg_addr == CFG_ADDR_W'(CFG_PERMUTE_ADDR)) permute_sel <= cfg_wdata[sel_bits-1:0];
      if (cfg_addr == CFG_ADDR_W'(CFG_RECOVER_ADDR)) recover_sel <= cfg_wdata[sel_bits-1:0];
      // Coefficient words update a pair at once
      for (int m = 0; m < n_coef_words; m++) begin
        if (cfg_addr == CFG_ADDR_W'(CFG_COEF_BASE + m)) begin
          coef_q[2*m]   <= cfg_wdata[data_width-1:0];
          coef_q[2*m+1] <= cfg_wdata[CFG_DATA_W/2 +: data_width];
        end
      end
    end
  end

  for (genvar n = 0; n < n_coef; n++) begin : g_coef
    assign coefs[n*data_width +: data_width] = coef_q[n];
  end

endmodule

/* lane_crossbar.sv */
// Lane select crossbar

`timescale 1ns/100ps

module lane_crossbar import bfly_pkg::*; #(
  parameter int data_width = DATA_WIDTH,
  parameter int bu_par     = BU_PAR
) (
  input  logic [2*bu_par*data_width-1:0]       lanes_in,
  input  logic [2*bu_par*$clog2(2*bu_par)-1:0] sel,
  output logic [2*bu_par*data_width-1:0]       lanes_out
);

  localparam int lanes = 2 * bu_par;
  localparam int sel_w = $clog2(lanes);

  logic [data_width-1:0] lane_arr [lanes];

  for (genvar k = 0; k < lanes; k++) begin : g_split
    assign lane_arr[k] = lanes_in[k*data_width +: data_width];
  end

  // Output lane i takes input lane named by field i
  for (genvar i = 0; i < lanes; i++) begin : g_pick
    assign lanes_out[i*data_width +: data_width] = lane_arr[sel[i*sel_w +: sel_w]];
  end

endmodule

/* sample_packer.sv */
// Serial to parallel sample packer

`timescale 1ns/100ps

module sample_packer import bfly_pkg::*; #(
  parameter int data_width = DATA_WIDTH,
  parameter int bu_par     = BU_PAR
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           up_vld,
  input  logic signed [data_width-1:0]   up_dat,
  output logic                           vec_vld,
  output logic [2*bu_par*data_width-1:0] vec_dat
);

  localparam int lanes = 2 * bu_par;
  localparam int cnt_w = $clog2(lanes);

  logic [cnt_w-1:0] lane_cnt;  // Next lane to fill
  logic             last_lane;

  assign last_lane = (lane_cnt == cnt_w'(lanes - 1));

  // Lane counter and full-vector strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt <= '0;
      vec_vld  <= 1'b0;
    end else begin
      vec_vld <= up_vld && last_lane;  // One cycle per full group
      if (up_vld) begin
        lane_cnt <= last_lane ? '0 : lane_cnt + 1'b1;
      end
    end
  end

  // First sample of a group lands in lane 0
  always_ff @(posedge clk) begin
    if (up_vld) begin
      vec_dat[lane_cnt*data_width +: data_width] <= up_dat;
    end
  end

endmodule

/* sources.f */
bfly_pkg.sv
sample_packer.sv
lane_crossbar.sv
bfly_unit.sv
bfly_datapath.sv
engine_cfg_regs.sv
bfly_engine_top.sv
tb_bfly_engine.sv

/* tb_bfly_engine.sv */
// Butterfly engine testbench

`timescale 1ns/100ps

module tb_bfly_engine import bfly_pkg::*; ();

  localparam int lanes       = 2 * BU_PAR;
  localparam int sel_w       = $clog2(lanes);
  localparam int vec_w       = lanes * DATA_WIDTH;
  localparam int drive_dly   = 2;    // ns after the rising edge
  localparam int out_delay   = 5;    // Eighth sample to dn_vld
  localparam int drain_limit = 100;

  logic                  clk;
  logic                  rst_n;
  logic                  up_vld;
  logic [DATA_WIDTH-1:0] up_dat;
  logic                  cfg_we;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic                  dn_vld;
  logic [vec_w-1:0]      dn_dat;

  int               perm_m [lanes];   // Model copy of the configuration
  int               rec_m  [lanes];
  int               coef_m [4*BU_PAR];
  logic [vec_w-1:0] exp_q [$];
  int               due_q [$];        // Cycle each vector is due
  logic [vec_w-1:0] model_vec;
  int               cyc = 0;
  int               last_drive = 0;
  int               data_errs = 0;
  int               time_errs = 0;
  int               file_errs = 0;

  bfly_engine_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .up_vld    (up_vld),
    .up_dat    (up_dat),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .dn_vld    (dn_vld),
    .dn_dat    (dn_dat)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  task automatic update_model_cfg(input logic [31:0] addr, input logic [31:0] data);
    if (addr == CFG_PERMUTE_ADDR) begin
      for (int i = 0; i < lanes; i++) perm_m[i] = data[i*sel_w +: sel_w];
    end else if (addr == CFG_RECOVER_ADDR) begin
      for (int i = 0; i < lanes; i++) rec_m[i] = data[i*sel_w +: sel_w];
    end else if (addr >= CFG_COEF_BASE && addr < CFG_COEF_BASE + 2*BU_PAR) begin
      coef_m[2*(addr-CFG_COEF_BASE)]   = $signed(data[DATA_WIDTH-1:0]);
      coef_m[2*(addr-CFG_COEF_BASE)+1] = $signed(data[CFG_DATA_W/2 +: DATA_WIDTH]);
    end
  endtask

  function automatic logic [vec_w-1:0] butterfly_model(input logic [vec_w-1:0] x);
    int               p [lanes];
    int               y [lanes];
    longint           acc;
    logic [vec_w-1:0] r;
    for (int i = 0; i < lanes; i++) p[i] = $signed(x[perm_m[i]*DATA_WIDTH +: DATA_WIDTH]);
    for (int u = 0; u < BU_PAR; u++) begin
      acc = longint'(p[2*u]) * coef_m[4*u] + longint'(p[2*u+1]) * coef_m[4*u+2];
      y[2*u] = int'(acc >>> FRAC_BITS);
      acc = longint'(p[2*u]) * coef_m[4*u+1] + longint'(p[2*u+1]) * coef_m[4*u+3];
      y[2*u+1] = int'(acc >>> FRAC_BITS);
    end
    for (int i = 0; i < lanes; i++) r[i*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(y[rec_m[i]]);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #drive_dly;
    up_vld = 1'b0;
    cfg_we = 1'b0;
  endtask

  task automatic write_cfg(input logic [31:0] addr, input logic [31:0] data);
    next_cycle();
    cfg_we    = 1'b1;
    cfg_addr  = addr[CFG_ADDR_W-1:0];
    cfg_wdata = data;
    update_model_cfg(addr, data);
  endtask

  // Gap idle cycles split the group in the middle
  task automatic send_group(input int gap, input logic [vec_w-1:0] x);
    for (int i = 0; i < lanes; i++) begin
      if (i == lanes / 2) repeat (gap) next_cycle();
      next_cycle();
      up_vld = 1'b1;
      up_dat = x[i*DATA_WIDTH +: DATA_WIDTH];
    end
    last_drive = cyc;
  endtask

  // Output scoreboard
  always @(negedge clk) begin : output_monitor
    logic [vec_w-1:0] want;
    int               due;
    if (rst_n && dn_vld) begin
      if (exp_q.size() == 0) begin
        $display("dn_vld rose at cycle %0d with no vector pending", cyc);
        time_errs++;
      end else begin
        want = exp_q.pop_front();
        due  = due_q.pop_front();
        if (cyc != due) begin
          $display("dn_vld came at cycle %0d instead of cycle %0d", cyc, due);
          time_errs++;
        end
        for (int k = 0; k < lanes; k++) begin
          if (dn_dat[k*DATA_WIDTH +: DATA_WIDTH] !== want[k*DATA_WIDTH +: DATA_WIDTH]) begin
            $display("Error dn_dat lane %0d: got %h, expected %h", k,
                     dn_dat[k*DATA_WIDTH +: DATA_WIDTH], want[k*DATA_WIDTH +: DATA_WIDTH]);
            data_errs++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    int                    fd;
    int                    n;
    int                    gap;
    byte                   tag;
    string                 line;
    logic [31:0]           addr;
    logic [31:0]           data;
    logic [DATA_WIDTH-1:0] word;
    logic [vec_w-1:0]      grp;
    up_vld    = 1'b0;
    up_dat    = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    rst_n     = 1'b0;
    for (int i = 0; i < lanes; i++) begin
      perm_m[i] = i;   // Identity after reset
      rec_m[i]  = i;
    end
    for (int i = 0; i < 4*BU_PAR; i++) coef_m[i] = 0;
    repeat (2) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;

    fd = $fopen("bfly_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open bfly_input.txt");
      file_errs++;
    end else begin
      while ($fscanf(fd, " %c", tag) == 1) begin
        if (tag == "#") begin
          n = $fgets(line, fd);
        end else if (tag == "W") begin
          n = $fscanf(fd, "%h %h", addr, data);
          write_cfg(addr, data);
        end else if (tag == "S") begin
          n = $fscanf(fd, "%h", gap);
          for (int i = 0; i < lanes; i++) begin
            n = $fscanf(fd, "%h", word);
            grp[i*DATA_WIDTH +: DATA_WIDTH] = word;
          end
          model_vec = butterfly_model(grp);  // Configuration as of this group
          send_group(gap, grp);
        end else if (tag == "E") begin
          for (int i = 0; i < lanes; i++) begin
            n = $fscanf(fd, "%h", word);
            grp[i*DATA_WIDTH +: DATA_WIDTH] = word;
          end
          if (grp !== model_vec) begin
            $display("Error bfly_input.txt E line: file %h, rule gives %h", grp, model_vec);
            file_errs++;
          end
          exp_q.push_back(grp);
          due_q.push_back(last_drive + out_delay);
        end else begin
          $display("Unknown line tag in bfly_input.txt");
          file_errs++;
        end
      end
      $fclose(fd);
    end

    // Drain the pipeline
    next_cycle();
    n = 0;
    while (exp_q.size() != 0 && n < drain_limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out with %0d expected vectors never delivered", exp_q.size());
      time_errs++;
    end
    repeat (4) @(posedge clk);  // Catches a stray extra vector

    $display("Errors: data %0d, timing %0d, file %0d", data_errs, time_errs, file_errs);
    if (data_errs + time_errs + file_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
